// File: design/eye_pkg.sv
/*
 * Eye tracker shared definitions
 * Widths, Camera Link polarities, UART bit timing and the types
 * passed between the measurement blocks
 */
package eye_pkg;

    // --------------------
    // Widths
    localparam int PIXEL_WIDTH  = 8;
    localparam int COORD_WIDTH  = 11;   // Up to 2048 pixels per axis
    localparam int SUM_S_WIDTH  = 20;
    localparam int SUM_SX_WIDTH = 28;
    localparam int SUM_SY_WIDTH = 28;

    // --------------------
    // Camera Link sync polarities
    localparam logic FVAL_ACTIVE = 1'b1;
    localparam logic LVAL_ACTIVE = 1'b1;
    localparam logic DVAL_ACTIVE = 1'b0;    // Camera drives DVAL active low

    typedef logic [PIXEL_WIDTH-1:0]  pixel_t;
    typedef logic [COORD_WIDTH-1:0]  coord_t;
    typedef logic [SUM_S_WIDTH-1:0]  sum_s_t;
    typedef logic [SUM_SX_WIDTH-1:0] sum_xy_t;
    typedef logic [7:0]              uart_byte_t;

    // --------------------
    // UART report
    localparam int         BIT_CYCLES    = 16;      // cclk cycles per bit
    localparam uart_byte_t REPORT_HEADER = 8'hA5;
    localparam int         REPORT_BYTES  = 12;      // Header plus 3 + 4 + 4

    // One conditioned camera clock
    typedef struct packed {
        logic   de;
        logic   line_end;
        logic   frame_start;
        logic   frame_end;
        pixel_t pix_l;
        pixel_t pix_r;
    } cam_beat_t;

    typedef struct packed {
        sum_s_t  sum_s;
        sum_xy_t sum_sx;
        sum_xy_t sum_sy;
    } grav_result_t;

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_t;

endpackage

// File: design/camera_input.sv
/*
 * Camera Link input conditioning
 * Samples FVAL, LVAL, DVAL and both pixel taps, normalizes the
 * sync polarities and forms the frame and line events
 */
module camera_input (
    input  logic               cclk,
    input  logic               rst_n,
    input  logic               fval,
    input  logic               lval,
    input  logic               dval,
    input  eye_pkg::pixel_t    data_l,
    input  eye_pkg::pixel_t    data_r,
    output eye_pkg::cam_beat_t beat
);
    import eye_pkg::*;

    logic   fval_q;
    logic   lval_q;
    logic   dval_q;
    pixel_t data_l_q;
    pixel_t data_r_q;
    logic   frame_act;
    logic   line_act;
    logic   data_act;
    logic   frame_prev;
    logic   line_prev;

    // --------------------
    // Input sampling
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            fval_q <= ~FVAL_ACTIVE;     // Syncs start out inactive
            lval_q <= ~LVAL_ACTIVE;
            dval_q <= ~DVAL_ACTIVE;
        end else begin
            fval_q <= fval;
            lval_q <= lval;
            dval_q <= dval;
        end
    end

    always_ff @(posedge cclk) begin
        data_l_q <= data_l;
        data_r_q <= data_r;
    end

    assign frame_act = (fval_q == FVAL_ACTIVE);
    assign line_act  = (lval_q == LVAL_ACTIVE);
    assign data_act  = (dval_q == DVAL_ACTIVE);

    // Previous levels for the edge events
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            frame_prev <= 1'b0;
            line_prev  <= 1'b0;
        end else begin
            frame_prev <= frame_act;
            line_prev  <= line_act;
        end
    end

    // --------------------
    // Beat output
    always_comb begin
        beat.de          = frame_act & line_act & data_act;
        beat.line_end    = line_prev & ~line_act;       // Falling edge of line
        beat.frame_start = frame_act & ~frame_prev;
        beat.frame_end   = frame_prev & ~frame_act;
        beat.pix_l       = data_l_q;
        beat.pix_r       = data_r_q;
    end

endmodule

// File: design/gravity_accum.sv
/*
 * Pupil centroid accumulation
 * Tracks pixel coordinates, marks dark pixels on both taps and sums
 * count, x and y per frame. Latches the sums at frame end when the
 * report path is free, otherwise the frame is dropped
 */
module gravity_accum (
    input  logic                  cclk,
    input  logic                  rst_n,
    input  eye_pkg::cam_beat_t    beat,
    input  eye_pkg::pixel_t       threshold,
    input  logic                  report_busy,
    output eye_pkg::grav_result_t result,
    output logic                  report_start
);
    import eye_pkg::*;

    typedef logic [COORD_WIDTH:0] step_t;   // Coordinate sum of one beat

    logic [COORD_WIDTH-2:0] col;            // Beat index within a line
    logic [COORD_WIDTH-2:0] col_base;
    coord_t                 row;
    coord_t                 row_base;
    coord_t                 x_l;
    coord_t                 x_r;
    logic                   dark_l;
    logic                   dark_r;
    logic                   take;
    logic [1:0]             cnt_add;
    step_t                  x_add;
    step_t                  y_add;
    sum_s_t                 acc_s;
    sum_s_t                 acc_s_next;
    sum_xy_t                acc_sx;
    sum_xy_t                acc_sx_next;
    sum_xy_t                acc_sy;
    sum_xy_t                acc_sy_next;

    // --------------------
    // Pixel coordinates
    assign col_base = (beat.frame_start || beat.line_end) ? '0 : col;
    assign row_base = beat.frame_start ? '0 : row;
    assign x_l      = {col_base, 1'b0};
    assign x_r      = {col_base, 1'b1};

    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else begin
            col <= beat.de ? col_base + 1'b1 : col_base;
            if (beat.frame_start) begin
                row <= '0;
            end else if (beat.line_end) begin
                row <= row + 1'b1;
            end
        end
    end

    // Dark test on both taps
    assign dark_l = beat.de && (beat.pix_l <= threshold);
    assign dark_r = beat.de && (beat.pix_r <= threshold);

    always_comb begin
        cnt_add = {1'b0, dark_l} + {1'b0, dark_r};
        x_add   = '0;
        y_add   = '0;
        if (dark_l) begin
            x_add = x_add + step_t'(x_l);
            y_add = y_add + step_t'(row_base);
        end
        if (dark_r) begin
            x_add = x_add + step_t'(x_r);
            y_add = y_add + step_t'(row_base);
        end
    end

    // --------------------
    // Accumulators, restarted by frame_start
    always_comb begin
        if (beat.frame_start) begin
            acc_s_next  = sum_s_t'(cnt_add);
            acc_sx_next = sum_xy_t'(x_add);
            acc_sy_next = sum_xy_t'(y_add);
        end else begin
            acc_s_next  = acc_s + sum_s_t'(cnt_add);
            acc_sx_next = acc_sx + sum_xy_t'(x_add);
            acc_sy_next = acc_sy + sum_xy_t'(y_add);
        end
    end

    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            acc_s  <= '0;
            acc_sx <= '0;
            acc_sy <= '0;
        end else begin
            acc_s  <= acc_s_next;
            acc_sx <= acc_sx_next;
            acc_sy <= acc_sy_next;
        end
    end

    // --------------------
    // Frame end hand-off
    assign take = beat.frame_end && !report_busy;   // Busy report drops this frame

    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            report_start <= 1'b0;
        end else begin
            report_start <= take;
        end
    end

    always_ff @(posedge cclk) begin
        if (take) begin
            result.sum_s  <= acc_s_next;
            result.sum_sx <= acc_sx_next;
            result.sum_sy <= acc_sy_next;
        end
    end

endmodule

// File: design/uart_report.sv
/*
 * Centroid report sequencer
 * Sends the header byte and the three frame sums, most significant
 * byte first, one byte per free transmitter slot
 */
module uart_report (
    input  logic                  cclk,
    input  logic                  rst_n,
    input  eye_pkg::grav_result_t result,
    input  logic                  report_start,
    input  logic                  tx_busy,
    output logic                  report_busy,
    output eye_pkg::uart_byte_t   tx_data,
    output logic                  tx_load
);
    import eye_pkg::*;

    typedef logic [$clog2(REPORT_BYTES + 1)-1:0] byte_idx_t;

    byte_idx_t                 byte_idx;    // Next byte to issue
    logic [REPORT_BYTES*8-1:0] report_vec;
    logic                      tx_free;
    logic                      all_sent;

    // --------------------
    // Report layout, header in the top byte
    assign report_vec = {
        REPORT_HEADER,
        {(24 - SUM_S_WIDTH){1'b0}},  result.sum_s,     // 3 bytes
        {(32 - SUM_SX_WIDTH){1'b0}}, result.sum_sx,    // 4 bytes
        {(32 - SUM_SY_WIDTH){1'b0}}, result.sum_sy     // 4 bytes
    };

    // Transmitter idle and no load still in flight
    assign tx_free  = report_busy && !tx_busy && !tx_load;
    assign all_sent = (byte_idx == byte_idx_t'(REPORT_BYTES));

    // --------------------
    // Byte sequencing
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            report_busy <= 1'b0;
            byte_idx    <= '0;
            tx_load     <= 1'b0;
        end else begin
            tx_load <= 1'b0;
            if (report_start) begin
                report_busy <= 1'b1;
                byte_idx    <= '0;
            end else if (tx_free) begin
                if (all_sent) begin
                    report_busy <= 1'b0;    // Last stop bit done
                end else begin
                    tx_load  <= 1'b1;
                    byte_idx <= byte_idx + 1'b1;
                end
            end
        end
    end

    // Byte select
    always_ff @(posedge cclk) begin
        if (tx_free && !all_sent) begin
            tx_data <= report_vec[(REPORT_BYTES - 1 - int'(byte_idx)) * 8 +: 8];
        end
    end

endmodule

// File: design/uart_tx.sv
/*
 * UART transmitter
 * One 8N1 frame per load, LSB first, bit period counted in cclk
 */
module uart_tx (
    input  logic                cclk,
    input  logic                rst_n,
    input  eye_pkg::uart_byte_t tx_data,
    input  logic                tx_load,
    output logic                tx_busy,
    output logic                uart_txd
);
    import eye_pkg::*;

    typedef logic [$clog2(BIT_CYCLES)-1:0] bit_cnt_t;

    tx_state_t  state;
    bit_cnt_t   bit_cnt;        // Cycles within the current bit
    logic [2:0] bit_idx;
    uart_byte_t shift_q;
    logic       bit_done;

    assign bit_done = (bit_cnt == bit_cnt_t'(BIT_CYCLES - 1));
    assign tx_busy  = (state != IDLE);

    // --------------------
    // Frame FSM
    always_ff @(posedge cclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            bit_cnt  <= '0;
            bit_idx  <= '0;
            uart_txd <= 1'b1;   // Line idles high
        end else begin
            bit_cnt <= bit_done ? '0 : bit_cnt + 1'b1;
            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    if (tx_load) begin
                        state    <= START;
                        uart_txd <= 1'b0;
                    end
                end
                START: begin
                    if (bit_done) begin
                        state    <= DATA;
                        bit_idx  <= '0;
                        uart_txd <= shift_q[0];
                    end
                end
                DATA: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            state    <= STOP;
                            uart_txd <= 1'b1;
                        end else begin
                            bit_idx  <= bit_idx + 1'b1;
                            uart_txd <= shift_q[0];
                        end
                    end
                end
                default: begin
                    if (bit_done) state <= IDLE;    // End of stop bit
                end
            endcase
        end
    end

    // Data shifter, next bit always in bit 0
    always_ff @(posedge cclk) begin
        if (state == IDLE && tx_load) begin
            shift_q <= tx_data;
        end else if (bit_done && (state == START || state == DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: design/eye_tracker_top.sv
/*
 * Eye tracker measurement path
 * Camera Link input, pupil centroid sums and the UART report,
 * all in the camera clock domain
 */
module eye_tracker_top (
    input  logic            cclk,
    input  logic            rst_n,
    input  logic            fval,
    input  logic            lval,
    input  logic            dval,
    input  eye_pkg::pixel_t data_l,
    input  eye_pkg::pixel_t data_r,
    input  eye_pkg::pixel_t threshold,
    output logic            uart_txd
);
    import eye_pkg::*;

    cam_beat_t    beat;
    grav_result_t result;
    logic         report_start;
    logic         report_busy;
    uart_byte_t   tx_data;
    logic         tx_load;
    logic         tx_busy;

    // --------------------
    // Camera side
    camera_input u_camera_input (
        .cclk   (cclk),
        .rst_n  (rst_n),
        .fval   (fval),
        .lval   (lval),
        .dval   (dval),
        .data_l (data_l),
        .data_r (data_r),
        .beat   (beat)
    );

    gravity_accum u_gravity_accum (
        .cclk         (cclk),
        .rst_n        (rst_n),
        .beat         (beat),
        .threshold    (threshold),
        .report_busy  (report_busy),
        .result       (result),
        .report_start (report_start)
    );

    // --------------------
    // Report side
    uart_report u_uart_report (
        .cclk(cclk), .rst_n(rst_n), .result(result), .report_start(report_start),
        .tx_busy(tx_busy), .report_busy(report_busy), .tx_data(tx_data), .tx_load(tx_load)
    );

    uart_tx u_uart_tx (
        .cclk(cclk), .rst_n(rst_n), .tx_data(tx_data), .tx_load(tx_load),
        .tx_busy(tx_busy), .uart_txd(uart_txd)
    );

endmodule

// File: test/tb_clock.sv
/*
 * Testbench clock source
 * Free-running camera clock with a 50 % duty cycle
 */
module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

// File: test/tb_eye_tracker.sv
/*
 * Eye tracker testbench
 * Drives Camera Link frames, decodes the UART reports and checks
 * them against centroid sums computed while each frame is driven
 */
module tb_eye_tracker;
    timeunit 1ns;
    timeprecision 1ps;
    import eye_pkg::*;

    localparam int          CLK_NS        = 40;
    localparam int          N_LINES       = 6;
    localparam int          N_BEATS       = 5;
    localparam int          FRAME_CYCLES  = 120;    // Upper bound for a full frame
    localparam int          N_FRAMES      = 9;
    localparam int          REPORT_CYCLES = REPORT_BYTES * 10 * BIT_CYCLES;
    localparam int          WATCHDOG_NS   =
        N_FRAMES * (FRAME_CYCLES + REPORT_CYCLES + 100) * 2 * CLK_NS;
    localparam logic [31:0] LFSR_SEED     = 32'h9043;

    logic         cclk;
    logic         rst_n;
    logic         fval;
    logic         lval;
    logic         dval;
    pixel_t       data_l;
    pixel_t       data_r;
    pixel_t       threshold;
    logic         uart_txd;
    logic [31:0]  lfsr;
    logic         first_frame_done;
    uart_byte_t   rx_q[$];              // Decoded UART bytes
    grav_result_t exp_q[$];             // Model sums of reported frames

    tb_clock #(.PERIOD_NS(CLK_NS)) u_clock (.clk(cclk));

    eye_tracker_top dut (
        .cclk      (cclk),
        .rst_n     (rst_n),
        .fval      (fval),
        .lval      (lval),
        .dval      (dval),
        .data_l    (data_l),
        .data_r    (data_r),
        .threshold (threshold),
        .uart_txd  (uart_txd)
    );

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic flag_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        abort_run();
    endtask

    // --------------------
    // Random pixels
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic take_bits(input int n, output logic [7:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[6:0], lfsr[0]};
        end
    endtask

    // Mode 0 mixed, mode 1 dark candidates only at thr and thr + 1, mode 2 all bright
    task automatic make_pixel(input int mode, input pixel_t thr, output pixel_t p);
        logic [7:0] r;
        logic [7:0] k;
        take_bits(8, r);
        take_bits(2, k);
        if (mode == 2) begin
            p = thr + 8'd1 + (r % (8'd255 - thr));
        end else if (k == 8'd0) begin
            p = thr;
        end else if (k == 8'd1) begin
            p = thr + 8'd1;
        end else begin
            p = (mode == 0) ? r : thr + 8'd2 + (r % (8'd254 - thr));
        end
    endtask

    function automatic grav_result_t add_pixel(input grav_result_t m, input pixel_t p,
                                               input int x, input int y, input pixel_t thr);
        if (p <= thr) begin
            m.sum_s  = m.sum_s + sum_s_t'(1);
            m.sum_sx = m.sum_sx + sum_xy_t'(x);
            m.sum_sy = m.sum_sy + sum_xy_t'(y);
        end
        return m;
    endfunction

    task automatic drive(input logic fv, input logic lv, input logic dv,
                         input pixel_t pl, input pixel_t pr);
        @(negedge cclk);
        fval   = fv;
        lval   = lv;
        dval   = dv;
        data_l = pl;
        data_r = pr;
    endtask

    // --------------------
    // Frame driver with reference model
    task automatic send_frame(input int lines, input int beats, input int mode,
                              input pixel_t thr, input bit keep);
        grav_result_t m;
        pixel_t       pl;
        pixel_t       pr;
        logic [7:0]   r;
        bit           mixed;
        m         = '0;
        mixed     = (mode == 0);
        threshold = thr;
        if (mixed) begin
            repeat (3) drive(~FVAL_ACTIVE, LVAL_ACTIVE, DVAL_ACTIVE, 8'd0, 8'd0); // No frame
        end
        drive(~FVAL_ACTIVE, ~LVAL_ACTIVE, DVAL_ACTIVE, 8'd0, 8'd0);
        drive(FVAL_ACTIVE, ~LVAL_ACTIVE, DVAL_ACTIVE, 8'd0, 8'd0);
        for (int y = 0; y < lines; y++) begin
            for (int c = 0; c < beats; c++) begin
                take_bits(2, r);
                if (mixed && r == 8'd0) begin
                    drive(FVAL_ACTIVE, LVAL_ACTIVE, ~DVAL_ACTIVE, 8'd0, 8'd0);
                end
                make_pixel(mode, thr, pl);
                make_pixel(mode, thr, pr);
                drive(FVAL_ACTIVE, LVAL_ACTIVE, DVAL_ACTIVE, pl, pr);
                m = add_pixel(m, pl, 2 * c, y, thr);
                m = add_pixel(m, pr, 2 * c + 1, y, thr);
            end
            repeat (2) drive(FVAL_ACTIVE, ~LVAL_ACTIVE, DVAL_ACTIVE, 8'd0, 8'd0); // Line gap
        end
        drive(~FVAL_ACTIVE, ~LVAL_ACTIVE, DVAL_ACTIVE, 8'd0, 8'd0);
        first_frame_done = 1'b1;
        repeat (3) drive(~FVAL_ACTIVE, ~LVAL_ACTIVE, ~DVAL_ACTIVE, 8'd0, 8'd0);
        if (keep) begin
            exp_q.push_back(m);
        end
    endtask

    // Waits for one whole report and compares it with the next model entry
    task automatic check_report();
        grav_result_t m;
        uart_byte_t   b [REPORT_BYTES];
        logic [23:0]  got_s;
        logic [31:0]  got_sx;
        logic [31:0]  got_sy;
        while (rx_q.size() < REPORT_BYTES) @(negedge cclk);
        m = exp_q.pop_front();
        for (int i = 0; i < REPORT_BYTES; i++) begin
            b[i] = rx_q.pop_front();
        end
        got_s  = {b[1], b[2], b[3]};
        got_sx = {b[4], b[5], b[6], b[7]};
        got_sy = {b[8], b[9], b[10], b[11]};
        assert (b[0] == REPORT_HEADER)
            else flag_mismatch($sformatf("header %02h, expected %02h", b[0], REPORT_HEADER));
        assert (got_s == 24'(m.sum_s))
            else flag_mismatch($sformatf("sum_s %0d, expected %0d", got_s, m.sum_s));
        assert (got_sx == 32'(m.sum_sx))
            else flag_mismatch($sformatf("sum_sx %0d, expected %0d", got_sx, m.sum_sx));
        assert (got_sy == 32'(m.sum_sy))
            else flag_mismatch($sformatf("sum_sy %0d, expected %0d", got_sy, m.sum_sy));
    endtask

    // --------------------
    // UART decoder samples each bit near both of its ends
    initial begin
        logic       a;
        logic       b;
        uart_byte_t d;
        @(posedge rst_n);
        forever begin
            @(negedge uart_txd);
            repeat (2) @(negedge cclk);
            for (int k = 0; k < 10; k++) begin
                a = uart_txd;
                repeat (BIT_CYCLES - 3) @(negedge cclk);
                b = uart_txd;
                assert (a == b)
                    else flag_mismatch($sformatf("uart_txd changed inside bit %0d", k));
                if (k == 0) begin
                    assert (a == 1'b0) else flag_mismatch("start bit is not low");
                end else if (k == 9) begin
                    assert (a == 1'b1) else flag_mismatch("stop bit is not high");
                end else begin
                    d = {a, d[7:1]};    // LSB first
                end
                if (k < 9) repeat (3) @(negedge cclk);
            end
            rx_q.push_back(d);
        end
    end

    idle_before_frame: assert property (@(posedge cclk) disable iff (!rst_n)
        !first_frame_done |-> uart_txd)
        else flag_mismatch("uart_txd left idle before the first frame ended");

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t, the reports did not arrive in time", $time);
        abort_run();
    end

    // --------------------
    // Test sequence
    initial begin
        lfsr             = LFSR_SEED;
        first_frame_done = 1'b0;
        rst_n            = 1'b0;
        fval             = ~FVAL_ACTIVE;
        lval             = ~LVAL_ACTIVE;
        dval             = ~DVAL_ACTIVE;
        data_l           = '0;
        data_r           = '0;
        threshold        = 8'd128;
        repeat (5) @(posedge cclk);
        @(negedge cclk);
        rst_n = 1'b1;
        repeat (20) @(negedge cclk);

        send_frame(N_LINES, N_BEATS, 0, 8'd128, 1'b1);  // Mixed gating frames
        check_report();
        send_frame(N_LINES, N_BEATS, 0, 8'd64, 1'b1);
        check_report();
        send_frame(N_LINES, N_BEATS, 0, 8'd200, 1'b1);
        check_report();
        send_frame(N_LINES, N_BEATS, 1, 8'd100, 1'b1);  // Threshold edge
        check_report();
        send_frame(N_LINES, N_BEATS, 2, 8'd100, 1'b1);  // No dark pixels
        check_report();

        // Short frames during a report are dropped
        send_frame(N_LINES, N_BEATS, 0, 8'd128, 1'b1);
        repeat (3) send_frame(2, 3, 0, 8'd128, 1'b0);
        check_report();
        repeat (REPORT_CYCLES + 100) @(posedge cclk);
        assert (rx_q.size() == 0)
            else flag_mismatch($sformatf("%0d bytes from dropped frames", rx_q.size()));

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: list.f
design/eye_pkg.sv
design/camera_input.sv
design/gravity_accum.sv
design/uart_report.sv
design/uart_tx.sv
design/eye_tracker_top.sv
test/tb_clock.sv
test/tb_eye_tracker.sv

// File: run.sh
#!/usr/bin/env bash
# Builds and runs the eye tracker testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

top=tb_eye_tracker
build_dir=obj_dir

verilator --binary --assert --timescale 1ns/1ps -Mdir "$build_dir" \
    --top-module "$top" -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$("./$build_dir/V$top" 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation run returned status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi

echo "Pass message not found in the simulation output"
exit 1
